// ==== verilog.f ====
source/tluh_pkg.sv
source/tluh_atomic_alu.sv
source/tluh_adapter_reg.sv
source/tluh_reg_file.sv
source/tluh_reg_top.sv
tests/tluh_reg_top_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

if ! rm -rf obj_dir; then
  echo "could not clear obj_dir"
  exit 1
fi

if ! verilator --binary --timing --assert -Wno-fatal -f verilog.f \
     --top-module tluh_reg_top_tb -o tluh_sim; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tluh_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TESTS PASSED" sim.log; then
  exit 0
fi
exit 1

// ==== tests/tluh_reg_top_tb.sv ====
`timescale 1ns/1ns

module tluh_reg_top_tb;

  localparam int RegAw     = 8;
  localparam int Words     = (2**RegAw) / 4;
  localparam int MaxCycles = 4000;  // ~60 transactions, each well under 30 cycles with stalls
  localparam logic [31:0] IdWord = 32'h544C5548;

  // one expected D beat
  typedef struct packed {
    tluh_pkg::tluh_d_op_e            op;
    logic [tluh_pkg::TL_SZW-1:0]     size;
    logic [tluh_pkg::TL_AIW-1:0]     src;
    logic [tluh_pkg::TL_DW-1:0]      data;
    logic                            err;
    logic                            chk;   // data is compared too
  } d_exp_t;

  logic                clk_i;
  logic                rst_ni;
  logic                d_ready;
  tluh_pkg::tluh_h2d_t a_drv;      // A side fields
  tluh_pkg::tluh_h2d_t tl_i;
  tluh_pkg::tluh_d2h_t tl_o;
  tluh_pkg::intent_t   hint_o;

  logic [31:0] ref_mem [Words];    // reference register contents
  d_exp_t      exp_q [$];          // D beats still due
  int          errors = 0, checks = 0, err_mark = 0, tests_run = 0, tests_failed = 0;
  int          cycles = 0;

  always_comb begin
    tl_i         = a_drv;
    tl_i.d_ready = d_ready;        // owned by the D monitor
  end

  tluh_reg_top #(.RegAw(RegAw)) tluh_reg_top_inst (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .tl_i   (tl_i),
    .tl_o   (tl_o),
    .hint_o (hint_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // run limit
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MaxCycles) begin
      $display("timeout, run still busy after %0d cycles", MaxCycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////
  function automatic int beats_of(input logic [2:0] size);
    return (size > 3'd2) ? (1 << (size - 3'd2)) : 1;  // 2^size/4, at least one
  endfunction

  // {carry out, new word} for an atomic on old
  function automatic logic [32:0] ref_atomic(input logic arith, input logic [2:0] fn,
                                             input logic [31:0] a, input logic [31:0] old,
                                             input logic cin);
    logic [32:0] sum;
    logic        a_lt_s, a_lt_u;
    sum    = 33'(a) + 33'(old) + 33'(cin);
    a_lt_s = $signed(a) < $signed(old);
    a_lt_u = a < old;
    if (arith) begin
      case (fn)
        3'd0:    return {1'b0, a_lt_s ? a : old};  // min
        3'd1:    return {1'b0, a_lt_s ? old : a};  // max
        3'd2:    return {1'b0, a_lt_u ? a : old};
        3'd3:    return {1'b0, a_lt_u ? old : a};
        3'd4:    return sum;                       // carry on top
        default: return {1'b0, old};
      endcase
    end
    case (fn)
      3'd0:    return {1'b0, a ^ old};
      3'd1:    return {1'b0, a | old};
      3'd2:    return {1'b0, a & old};
      3'd3:    return {1'b0, a};                   // swap keeps the new word
      default: return {1'b0, old};
    endcase
  endfunction

  ////////////////////////////////////////
  // A channel driver
  ////////////////////////////////////////
  task automatic send_a(input tluh_pkg::tluh_a_op_e op, input logic [2:0] param,
                        input logic [2:0] size, input logic [7:0] src,
                        input logic [31:0] addr, input logic [3:0] mask,
                        input logic [31:0] data);
    logic [3:0] exp_blocks;
    exp_blocks = 4'(beats_of(size));
    @(negedge clk_i);
    a_drv.a_valid   = 1'b1;
    a_drv.a_opcode  = op;
    a_drv.a_param   = param;
    a_drv.a_size    = size;
    a_drv.a_source  = src;
    a_drv.a_address = addr;
    a_drv.a_mask    = mask;
    a_drv.a_data    = data;
    #1;
    while (!tl_o.a_ready) begin    // a_ready only moves on the rising edge
      @(negedge clk_i);
      #1;
    end
    if (op == tluh_pkg::INTENT) begin  // hint lives in the accept cycle
      checks++;
      assert (hint_o.ie && hint_o.intent == param[1:0] && hint_o.blocks == exp_blocks) else begin
        $display("FAILED %0t: hint ie %0b intent %0d blocks %0d, expected intent %0d blocks %0d",
                 $time, hint_o.ie, hint_o.intent, hint_o.blocks, param[1:0], exp_blocks);
        errors++;
      end
    end
    @(negedge clk_i);
    a_drv.a_valid = 1'b0;
  endtask

  task automatic wait_d();
    while (exp_q.size() != 0) @(posedge clk_i);
  endtask

  task automatic tl_put(input int idx, input logic [2:0] size, input logic [3:0] mask);
    d_exp_t               e;
    logic [7:0]           src;
    logic [31:0]          data;
    int                   w;
    tluh_pkg::tluh_a_op_e op;
    src = 8'($urandom);
    op  = tluh_pkg::PUT_PARTIAL_DATA;
    if (mask == 4'hF) op = tluh_pkg::PUT_FULL_DATA;
    e = '{op: tluh_pkg::ACCESS_ACK, size: size, src: src, data: '0, err: 1'b0, chk: 1'b0};
    for (int k = 0; k < beats_of(size); k++) begin
      if ((idx + k) % Words == 0) e.err = 1'b1;   // id word refuses writes
    end
    exp_q.push_back(e);                           // one ack for the whole burst
    for (int k = 0; k < beats_of(size); k++) begin
      w    = (idx + k) % Words;
      data = $urandom;
      for (int b = 0; b < 4; b++) begin
        if (mask[b] && w != 0) ref_mem[w][8*b +: 8] = data[8*b +: 8];
      end
      send_a(op, 3'd0, size, src, 32'(w * 4), mask, data);
    end
    wait_d();
  endtask

  task automatic tl_get(input int idx, input logic [2:0] size);
    d_exp_t     e;
    logic [7:0] src;
    src = 8'($urandom);
    for (int k = 0; k < beats_of(size); k++) begin
      e = '{op: tluh_pkg::ACCESS_ACK_DATA, size: size, src: src,
            data: ref_mem[(idx + k) % Words], err: 1'b0, chk: 1'b1};
      exp_q.push_back(e);
    end
    send_a(tluh_pkg::GET, 3'd0, size, src, 32'(idx * 4), 4'hF, '0);
    wait_d();
  endtask

  // one atomic beat, carry chains into the next beat of a burst
  task automatic tl_atomic(input logic arith, input logic [2:0] fn, input int idx,
                           input logic [2:0] size, input logic [7:0] src,
                           input logic [31:0] data, inout logic carry);
    d_exp_t               e;
    logic [32:0]          r;
    tluh_pkg::tluh_a_op_e op;
    op = tluh_pkg::LOGICAL_DATA;
    if (arith) op = tluh_pkg::ARITHMETIC_DATA;
    r = ref_atomic(arith, fn, data, ref_mem[idx], carry);
    e = '{op: tluh_pkg::ACCESS_ACK_DATA, size: size, src: src,
          data: ref_mem[idx], err: 1'b0, chk: 1'b1};   // old word comes back
    exp_q.push_back(e);
    ref_mem[idx] = r[31:0];
    carry        = r[32];
    send_a(op, fn, size, src, 32'(idx * 4), 4'hF, data);
    wait_d();
  endtask

  task automatic tl_hint(input logic [2:0] param, input logic [2:0] size);
    d_exp_t     e;
    logic [7:0] src;
    src = 8'($urandom);
    e   = '{op: tluh_pkg::HINT_ACK, size: size, src: src, data: '0, err: 1'b0, chk: 1'b0};
    exp_q.push_back(e);
    send_a(tluh_pkg::INTENT, param, size, src, 32'h40, 4'hF, '0);
    wait_d();
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors == err_mark) begin
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: fail, %0d errors", name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  ////////////////////////////////////////
  // D channel monitor and checks
  ////////////////////////////////////////
  initial begin : d_monitor
    d_exp_t      e;
    logic        stalled;
    logic [31:0] held;
    d_ready = 1'b0;
    stalled = 1'b0;
    held    = '0;
    forever begin
      @(negedge clk_i);
      d_ready = ($urandom % 4) != 0;   // stall about one cycle in four
      #1;
      if (stalled) begin               // beat held back last cycle
        checks++;
        assert (tl_o.d_valid && !tl_o.a_ready && tl_o.d_data == held) else begin
          $display("FAILED %0t: D beat not held or a_ready high while d_ready was low", $time);
          errors++;
        end
      end
      stalled = rst_ni && tl_o.d_valid && !d_ready;
      held    = tl_o.d_data;
      if (rst_ni && tl_o.d_valid && d_ready) begin  // taken at the next rising edge
        if (exp_q.size() == 0) begin
          $display("D beat at %0t arrived with no request waiting for one", $time);
          errors++;
        end else begin
          e = exp_q.pop_front();
          checks++;
          assert (tl_o.d_opcode == e.op && tl_o.d_size == e.size && tl_o.d_source == e.src)
          else begin
            $display("FAILED %0t: D op %0d size %0d source %0d, expected %0d %0d %0d", $time,
                     tl_o.d_opcode, tl_o.d_size, tl_o.d_source, e.op, e.size, e.src);
            errors++;
          end
          assert (tl_o.d_param == 3'd0 && tl_o.d_sink == 1'b0) else begin
            $display("FAILED %0t: d_param %0d d_sink %0b, expected both zero", $time,
                     tl_o.d_param, tl_o.d_sink);
            errors++;
          end
          assert (tl_o.d_error == e.err) else begin
            $display("FAILED %0t: d_error %0b, expected %0b", $time, tl_o.d_error, e.err);
            errors++;
          end
          assert (!e.chk || tl_o.d_data == e.data) else begin
            $display("FAILED %0t: d_data %h, expected %h", $time, tl_o.d_data, e.data);
            errors++;
          end
        end
      end
    end
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////
  initial begin : main_seq
    int         idx;
    logic       carry;
    logic [7:0] src;
    void'($urandom(6932));
    a_drv  = '0;
    rst_ni = 1'b0;
    for (int w = 0; w < Words; w++) ref_mem[w] = '0;
    ref_mem[0] = IdWord;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    for (int n = 0; n < 8; n++) begin
      idx = 1 + int'($urandom % (Words - 1));
      tl_put(idx, 3'd2, 4'(1 + $urandom % 15));
      tl_get(idx, 3'd2);
    end
    report_test("single put and get");

    tl_put(8, 3'd4, 4'hF);
    tl_get(8, 3'd4);
    tl_put(Words - 2, 3'd4, 4'hF);     // crosses the top, hits word 0
    tl_get(Words - 2, 3'd4);
    report_test("burst put and get");

    for (int fn = 0; fn < 9; fn++) begin  // 5 arithmetic then 4 logical
      idx   = 1 + int'($urandom % (Words - 1));
      carry = 1'b0;
      src   = 8'($urandom);
      tl_put(idx, 3'd2, 4'hF);          // fresh old word
      tl_atomic(fn < 5, 3'(fn < 5 ? fn : fn - 5), idx, 3'd2, src, $urandom, carry);
      tl_get(idx, 3'd2);
    end
    src   = 8'($urandom);
    carry = 1'b0;
    tl_atomic(1'b0, 3'd3, 20, 3'd2, src, 32'hFFFF_FFF0, carry);  // swap in known words
    tl_atomic(1'b0, 3'd3, 21, 3'd2, src, 32'h0000_0005, carry);
    carry = 1'b0;
    tl_atomic(1'b1, 3'd4, 20, 3'd3, src, 32'h0000_0030, carry);  // overflows word 20
    tl_atomic(1'b1, 3'd4, 21, 3'd3, src, 32'h0000_0001, carry);  // takes the carry
    tl_get(20, 3'd3);
    report_test("atomics");

    tl_put(0, 3'd2, 4'hF);
    tl_get(0, 3'd2);
    report_test("id word");

    tl_hint(3'd0, 3'd2);               // prefetchRead, one block
    tl_hint(3'd1, 3'd5);               // prefetchWrite, eight blocks
    report_test("intent");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== source/tluh_reg_top.sv ====
`timescale 1ns/1ns

module tluh_reg_top #(
  parameter int RegAw = 8
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  tluh_pkg::tluh_h2d_t tl_i,
  output tluh_pkg::tluh_d2h_t tl_o,
  output tluh_pkg::intent_t   hint_o   // prefetch hint out
);

  tluh_pkg::reg_req_t reg_req;
  tluh_pkg::reg_rsp_t reg_rsp;

  tluh_adapter_reg #(.RegAw(RegAw)) tluh_adapter_reg_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .tl_i      (tl_i),
    .tl_o      (tl_o),
    .reg_req_o (reg_req),
    .reg_rsp_i (reg_rsp),
    .intent_o  (hint_o)
  );

  tluh_reg_file #(.RegAw(RegAw)) tluh_reg_file_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .reg_req_i (reg_req),
    .reg_rsp_o (reg_rsp)
  );

endmodule

// ==== source/tluh_reg_file.sv ====
`timescale 1ns/1ns

module tluh_reg_file #(
  parameter int RegAw = 8
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  tluh_pkg::reg_req_t reg_req_i,
  output tluh_pkg::reg_rsp_t reg_rsp_o
);

  localparam int DW       = tluh_pkg::TL_DW;
  localparam int DBW      = tluh_pkg::TL_DBW;
  localparam int Words    = (2**RegAw) / DBW;
  localparam int IW       = RegAw - 2;        // word index bits
  localparam logic [DW-1:0] IdValue = 32'h544C5548;

  logic [DW-1:0] mem [Words];
  logic [IW-1:0] idx;
  logic          id_hit;      // word 0, read only

  assign idx    = reg_req_i.addr[RegAw-1:2];
  assign id_hit = idx == '0;

  ////////////////////////////////////////
  // read side, combinational
  ////////////////////////////////////////
  always_comb begin
    reg_rsp_o.rdata = '0;
    if (reg_req_i.re) reg_rsp_o.rdata = id_hit ? IdValue : mem[idx];
    reg_rsp_o.error = reg_req_i.we & id_hit;  // write to id word
  end

  // byte enabled write
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int w = 0; w < Words; w++) begin
        mem[w] <= '0;
      end
    end else if (reg_req_i.we && !id_hit) begin
      for (int b = 0; b < DBW; b++) begin
        if (reg_req_i.be[b]) mem[idx][8*b +: 8] <= reg_req_i.wdata[8*b +: 8];
      end
    end
  end

endmodule

// ==== source/tluh_adapter_reg.sv ====
`timescale 1ns/1ns

module tluh_adapter_reg #(
  parameter int RegAw = 8
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  tluh_pkg::tluh_h2d_t tl_i,
  output tluh_pkg::tluh_d2h_t tl_o,
  output tluh_pkg::reg_req_t  reg_req_o,
  input  tluh_pkg::reg_rsp_t  reg_rsp_i,
  output tluh_pkg::intent_t   intent_o
);

  localparam int BW      = tluh_pkg::TL_BEATSMAXW;
  localparam int DW      = tluh_pkg::TL_DW;
  localparam int AW      = tluh_pkg::TL_AW;
  localparam int SZ_WORD = $clog2(tluh_pkg::TL_DBW);  // size of one beat

  typedef enum logic {
    GET_IDLE,
    READ_NEXT_BEAT      // later words go out on each d_ack
  } get_state_e;

  typedef enum logic {
    PUT_IDLE,
    WRITE_NEXT_BEAT     // waiting for more A beats
  } put_state_e;

  typedef enum logic [1:0] {
    ATOMIC_IDLE,
    PERFORM_WRITE,      // alu result goes to the register
    NEXT_BEAT           // waiting for next A beat of the burst
  } atomic_state_e;

  get_state_e    get_state;
  put_state_e    put_state;
  atomic_state_e atomic_state;

  logic outstanding;  // one response pending
  logic a_ack, d_ack;

  logic is_get, is_put, is_atomic, is_intent;
  logic get_first, get_more, put_beat, atomic_beat, atomic_wr;
  logic cont_beat;    // A beat continues a burst
  logic re, we;

  logic [BW-1:0]    burst_len, beats_m1;
  logic [BW-1:0]    beats_cnt;  // words still to go
  logic [RegAw-1:0] beat_addr;  // last word touched
  logic [RegAw-1:0] next_addr;
  logic [RegAw-1:0] req_addr;

  // response capture
  logic [DW-1:0]                   rdata;
  logic [tluh_pkg::TL_AIW-1:0]     reqid;
  logic [tluh_pkg::TL_SZW-1:0]     reqsz;
  tluh_pkg::tluh_d_op_e            rspop;
  logic                            err_q;

  // atomic operands
  logic [DW-1:0]                 op_data;
  logic [tluh_pkg::TL_DBW-1:0]   op_mask;
  logic [2:0]                    op_function;
  logic                          op_arith;
  logic                          op_cin;
  logic [DW-1:0]                 alu_result;
  logic                          alu_cout;

  assign a_ack = tl_i.a_valid & tl_o.a_ready;
  assign d_ack = tl_o.d_valid & tl_i.d_ready;

  ////////////////////////////////////////
  // decode
  ////////////////////////////////////////
  assign is_get    = tl_i.a_opcode == tluh_pkg::GET;
  assign is_put    = (tl_i.a_opcode == tluh_pkg::PUT_FULL_DATA) |
                     (tl_i.a_opcode == tluh_pkg::PUT_PARTIAL_DATA);
  assign is_atomic = (tl_i.a_opcode == tluh_pkg::ARITHMETIC_DATA) |
                     (tl_i.a_opcode == tluh_pkg::LOGICAL_DATA);
  assign is_intent = tl_i.a_opcode == tluh_pkg::INTENT;

  // beats in request, 2^size/4, one for sub-word sizes
  assign burst_len = (tl_i.a_size > SZ_WORD) ? (BW'(1) << (tl_i.a_size - SZ_WORD)) : BW'(1);
  assign beats_m1  = burst_len - 1'b1;

  assign get_first   = a_ack & is_get;
  assign get_more    = (get_state == READ_NEXT_BEAT) && (beats_cnt != '0);
  assign put_beat    = a_ack & is_put;
  assign atomic_beat = a_ack & is_atomic;
  assign atomic_wr   = atomic_state == PERFORM_WRITE;
  assign cont_beat   = (put_state == WRITE_NEXT_BEAT) || (atomic_state == NEXT_BEAT);

  assign re = get_first | (d_ack & get_more) | atomic_beat;
  assign we = put_beat | atomic_wr;

  // word aligned, wraps at top of reg space
  assign next_addr = beat_addr + RegAw'(tluh_pkg::TL_DBW);

  always_comb begin
    if (atomic_wr)                                    req_addr = beat_addr;  // same word as read
    else if (get_state == READ_NEXT_BEAT || cont_beat) req_addr = next_addr;
    else                                              req_addr = {tl_i.a_address[RegAw-1:2], 2'b00};
  end

  assign reg_req_o = '{
    re:    re,
    we:    we,
    addr:  {{(AW-RegAw){1'b0}}, req_addr},
    wdata: atomic_wr ? alu_result : tl_i.a_data,
    be:    atomic_wr ? op_mask : tl_i.a_mask
  };

  // hint is visible in the accept cycle only
  assign intent_o = '{
    ie:     a_ack & is_intent,
    intent: tl_i.a_param[1:0],
    blocks: burst_len
  };

  ////////////////////////////////////////
  // control fsms
  ////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding  <= 1'b0;
      get_state    <= GET_IDLE;
      put_state    <= PUT_IDLE;
      atomic_state <= ATOMIC_IDLE;
      beats_cnt    <= '0;
      beat_addr    <= '0;
    end else begin
      if (re | we) beat_addr <= req_addr;
      if (d_ack & ~get_more) outstanding <= 1'b0;  // last beat of response

      case (get_state)
        GET_IDLE: if (get_first) begin
          outstanding <= 1'b1;
          if (beats_m1 != '0) begin
            get_state <= READ_NEXT_BEAT;
            beats_cnt <= beats_m1;
          end
        end
        READ_NEXT_BEAT: if (d_ack) begin
          if (get_more) beats_cnt <= beats_cnt - 1'b1;
          else          get_state <= GET_IDLE;
        end
        default: get_state <= GET_IDLE;
      endcase

      case (put_state)
        PUT_IDLE: if (put_beat) begin
          if (beats_m1 != '0) begin
            put_state <= WRITE_NEXT_BEAT;
            beats_cnt <= beats_m1;
          end else begin
            outstanding <= 1'b1;
          end
        end
        WRITE_NEXT_BEAT: if (put_beat) begin
          beats_cnt <= beats_cnt - 1'b1;
          if (beats_cnt == BW'(1)) begin  // final beat, ack once
            put_state   <= PUT_IDLE;
            outstanding <= 1'b1;
          end
        end
        default: put_state <= PUT_IDLE;
      endcase

      case (atomic_state)
        ATOMIC_IDLE: if (atomic_beat) begin
          outstanding  <= 1'b1;
          beats_cnt    <= beats_m1;
          atomic_state <= PERFORM_WRITE;
        end
        PERFORM_WRITE: atomic_state <= (beats_cnt != '0) ? NEXT_BEAT : ATOMIC_IDLE;
        NEXT_BEAT: if (atomic_beat) begin
          outstanding  <= 1'b1;
          beats_cnt    <= beats_cnt - 1'b1;
          atomic_state <= PERFORM_WRITE;
        end
        default: atomic_state <= ATOMIC_IDLE;
      endcase

      if (a_ack & is_intent) outstanding <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // payload capture
  ////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (re) rdata <= reg_rsp_i.rdata;  // old word for atomics too
    if (atomic_beat) begin
      op_data     <= tl_i.a_data;
      op_mask     <= tl_i.a_mask;
      op_function <= tl_i.a_param;
      op_arith    <= tl_i.a_opcode == tluh_pkg::ARITHMETIC_DATA;
    end
    if (atomic_beat && atomic_state == ATOMIC_IDLE) op_cin <= 1'b0;
    else if (atomic_wr)                             op_cin <= alu_cout;  // chain add carry
    if (a_ack & ~cont_beat) begin
      reqid <= tl_i.a_source;
      reqsz <= tl_i.a_size;
      err_q <= reg_rsp_i.error;
      if (is_get | is_atomic) rspop <= tluh_pkg::ACCESS_ACK_DATA;
      else if (is_intent)     rspop <= tluh_pkg::HINT_ACK;
      else                    rspop <= tluh_pkg::ACCESS_ACK;
    end else if (re | we) begin
      err_q <= err_q | reg_rsp_i.error;  // sticky over the burst
    end
  end

  assign tl_o = '{
    a_ready:  ~outstanding,
    d_valid:  outstanding,
    d_opcode: rspop,
    d_param:  3'b000,
    d_size:   reqsz,
    d_source: reqid,
    d_sink:   1'b0,
    d_data:   rdata,
    d_error:  err_q | (atomic_wr & reg_rsp_i.error)  // atomic write error shows at once
  };

  tluh_atomic_alu tluh_atomic_alu_inst (
    .op1_i      (op_data),
    .op2_i      (rdata),
    .cin_i      (op_cin),
    .arith_i    (op_arith),
    .function_i (op_function),
    .result_o   (alu_result),
    .cout_o     (alu_cout)
  );

endmodule

// ==== source/tluh_atomic_alu.sv ====
`timescale 1ns/1ns

module tluh_atomic_alu (
  input  logic [tluh_pkg::TL_DW-1:0] op1_i,       // operand from A data
  input  logic [tluh_pkg::TL_DW-1:0] op2_i,       // old register word
  input  logic                       cin_i,
  input  logic                       arith_i,     // 1 arithmetic, 0 logical
  input  logic [2:0]                 function_i,
  output logic [tluh_pkg::TL_DW-1:0] result_o,
  output logic                       cout_o
);

  localparam int DW = tluh_pkg::TL_DW;

  logic [DW:0] sum;       // carry in the top bit
  logic        lt_signed;
  logic        lt_unsigned;

  assign sum         = {1'b0, op1_i} + {1'b0, op2_i} + {{DW{1'b0}}, cin_i};
  assign lt_signed   = $signed(op1_i) < $signed(op2_i);
  assign lt_unsigned = op1_i < op2_i;

  // carry only matters for add
  assign cout_o = sum[DW];

  always_comb begin
    result_o = op2_i;  // unknown function keeps the word
    if (arith_i) begin
      case (function_i)
        tluh_pkg::ARITH_MIN:  result_o = lt_signed   ? op1_i : op2_i;
        tluh_pkg::ARITH_MAX:  result_o = lt_signed   ? op2_i : op1_i;
        tluh_pkg::ARITH_MINU: result_o = lt_unsigned ? op1_i : op2_i;
        tluh_pkg::ARITH_MAXU: result_o = lt_unsigned ? op2_i : op1_i;
        tluh_pkg::ARITH_ADD:  result_o = sum[DW-1:0];
        default:              result_o = op2_i;
      endcase
    end else begin
      case (function_i)
        tluh_pkg::LOGIC_XOR:  result_o = op1_i ^ op2_i;
        tluh_pkg::LOGIC_OR:   result_o = op1_i | op2_i;
        tluh_pkg::LOGIC_AND:  result_o = op1_i & op2_i;
        tluh_pkg::LOGIC_SWAP: result_o = op1_i;   // store new, old goes back on D
        default:              result_o = op2_i;
      endcase
    end
  end

endmodule

// ==== source/tluh_pkg.sv ====
package tluh_pkg;

  ////////////////////////////////////////
  // link widths
  ////////////////////////////////////////
  parameter int TL_DW        = 32;         // data bits per beat
  parameter int TL_DBW       = TL_DW / 8;  // bytes per beat
  parameter int TL_AW        = 32;         // address
  parameter int TL_SZW       = 3;          // log2 of byte count
  parameter int TL_AIW       = 8;          // source id
  parameter int TL_BEATSMAXW = 4;          // beat counter

  // A channel opcodes, TileLink encodings
  typedef enum logic [2:0] {
    PUT_FULL_DATA    = 3'h0,
    PUT_PARTIAL_DATA = 3'h1,
    ARITHMETIC_DATA  = 3'h2,
    LOGICAL_DATA     = 3'h3,
    GET              = 3'h4,
    INTENT           = 3'h5   // prefetch hint
  } tluh_a_op_e;

  // D channel opcodes
  typedef enum logic [2:0] {
    ACCESS_ACK      = 3'h0,
    ACCESS_ACK_DATA = 3'h1,
    HINT_ACK        = 3'h2
  } tluh_d_op_e;

  // a_param of ArithmeticData
  typedef enum logic [2:0] {
    ARITH_MIN  = 3'd0,
    ARITH_MAX  = 3'd1,
    ARITH_MINU = 3'd2,
    ARITH_MAXU = 3'd3,
    ARITH_ADD  = 3'd4
  } tluh_arith_e;

  // a_param of LogicalData
  typedef enum logic [2:0] {
    LOGIC_XOR  = 3'd0,
    LOGIC_OR   = 3'd1,
    LOGIC_AND  = 3'd2,
    LOGIC_SWAP = 3'd3
  } tluh_logic_e;

  ////////////////////////////////////////
  // channel bundles
  ////////////////////////////////////////
  typedef struct packed {
    logic                a_valid;
    tluh_a_op_e          a_opcode;
    logic [2:0]          a_param;
    logic [TL_SZW-1:0]   a_size;
    logic [TL_AIW-1:0]   a_source;
    logic [TL_AW-1:0]    a_address;
    logic [TL_DBW-1:0]   a_mask;
    logic [TL_DW-1:0]    a_data;
    logic                d_ready;
  } tluh_h2d_t;

  typedef struct packed {
    logic                a_ready;
    logic                d_valid;
    tluh_d_op_e          d_opcode;
    logic [2:0]          d_param;
    logic [TL_SZW-1:0]   d_size;
    logic [TL_AIW-1:0]   d_source;
    logic                d_sink;
    logic [TL_DW-1:0]    d_data;
    logic                d_error;
  } tluh_d2h_t;

  // register side, plain strobes
  typedef struct packed {
    logic                re;
    logic                we;
    logic [TL_AW-1:0]    addr;    // low RegAw bits decoded
    logic [TL_DW-1:0]    wdata;
    logic [TL_DBW-1:0]   be;
  } reg_req_t;

  typedef struct packed {
    logic [TL_DW-1:0]    rdata;
    logic                error;
  } reg_rsp_t;

  typedef struct packed {
    logic                    ie;      // one cycle pulse
    logic [1:0]              intent;  // 0 prefetchRead, 1 prefetchWrite
    logic [TL_BEATSMAXW-1:0] blocks;  // beats covered
  } intent_t;

endpackage
